/* build.f */
+incdir+source
source/rv_pkg.sv
source/rv_decode.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_bus_arbiter.sv
source/rv_core.sv
sim/rv_assertions.sv
sim/rv_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_tb \
  -f build.f --Mdir obj_dir -o rv_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit $status
fi

./obj_dir/rv_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

/* sim/rv_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module rv_tb;
  import rv_pkg::*;

  localparam int PROG_LEN = 200;
  localparam int IDLE_CYCLES = 10;

  logic  clk;
  logic  reset;
  logic  mem_valid;
  logic  mem_instr;
  logic  mem_ready;
  word_t mem_addr;
  word_t mem_wdata;
  strb_t mem_wstrb;
  word_t mem_rdata;
  logic  trap;

  word_t mem [512];
  word_t ref_mem [512];
  word_t exp_fetch [$];
  word_t exp_waddr [$];
  word_t exp_wdata [$];
  strb_t exp_wstrb [$];
  logic  busy;
  int    delay;
  logic  running;
  int    cycles;
  int    limit;

  rv_core i_dut (
    .clk, .reset, .mem_valid, .mem_instr, .mem_ready, .mem_addr, .mem_wdata, .mem_wstrb,
    .mem_rdata, .trap
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at time %0t: %s is %h, expected %h",
        $time, what, got, exp));
    end
  endtask

  task automatic check_strb(input string what, input strb_t got, input strb_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at time %0t: %s is %b, expected %b",
        $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at time %0t: %s is %b, expected %b",
        $time, what, got, exp));
    end
  endtask

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
      input logic [2:0] f3, input reg_addr_t rd, input logic [4:0] op);
    return {imm, rs1, f3, rd, op, 2'b11};
  endfunction

  // stores always use x0 as base
  function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
      input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], `RV_OP_STORE, 2'b11};
  endfunction

  function automatic word_t enc_b(input logic [12:0] off, input reg_addr_t rs1,
      input reg_addr_t rs2, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH, 2'b11};
  endfunction

  function automatic word_t enc_j(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL, 2'b11};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
      input logic [4:0] op);
    return {imm, rd, op, 2'b11};
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
      input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `RV_OP_REG, 2'b11};
  endfunction

  function automatic logic [11:0] align_off(input logic [11:0] off, input logic [1:0] size);
    case (size)
      2'b01:   return {off[11:1], 1'b0};
      2'b10:   return {off[11:2], 2'b00};
      default: return off;
    endcase
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
      input word_t a, input word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return word_t'($signed(a) < $signed(b));
      3'd3:    return word_t'(a < b);
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic fill_memory();
    word_t addr;
    for (int i = 0; i < 512; i++) begin
      addr = word_t'(4 * i);
      mem[i] = (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
    end
  endtask

  task automatic gen_program();
    word_t       rnd;
    word_t       fwd;
    word_t       tgt;
    int          kind;
    int          span;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  f3;
    logic [11:0] off;
    for (int k = 0; k < PROG_LEN; k++) begin
      rnd  = $urandom;
      kind = $urandom % 9;
      // jumps stay forward and land at most on the final word
      span = (PROG_LEN - k < 8) ? PROG_LEN - k : 8;
      fwd  = word_t'(4 * (1 + $urandom % span));
      tgt  = word_t'(4 * k) + fwd;
      rd   = {2'b00, rnd[2:0]};
      rs1  = {2'b00, rnd[5:3]};
      rs2  = {2'b00, rnd[8:6]};
      f3   = rnd[11:9];
      off  = {2'b01, rnd[21:12]};
      case (kind)
        0: mem[k] = enc_u(rnd[31:12], rd, `RV_OP_LUI);
        1: mem[k] = enc_u(rnd[31:12], rd, `RV_OP_AUIPC);
        2: begin
          if (f3 == 3'd1) begin
            off = {7'b0, rnd[16:12]};
          end else if (f3 == 3'd5) begin
            off = {rnd[31] ? `RV_F7_ALT : `RV_F7_BASE, rnd[16:12]};
          end else begin
            off = rnd[31:20];
          end
          mem[k] = enc_i(off, rs1, f3, rd, `RV_OP_IMM);
        end
        3: mem[k] = enc_r((rnd[31] && (f3 == 3'd0 || f3 == 3'd5)) ? `RV_F7_ALT : `RV_F7_BASE,
          rs2, rs1, f3, rd);
        4: begin
          if (f3[2:1] == 2'b01) begin
            f3[1] = 1'b0;
          end
          mem[k] = enc_b(fwd[12:0], rs1, rs2, f3);
        end
        5: mem[k] = enc_j(fwd[20:0], rd);
        6: begin
          if (f3 == 3'd3 || f3 > 3'd5) begin
            f3 = {f3[2], 1'b0, f3[0]};
          end
          mem[k] = enc_i(align_off(off, f3[1:0]), 5'd0, f3, rd, `RV_OP_LOAD);
        end
        7: begin
          f3 = {1'b0, rnd[10:9]};
          if (f3 == 3'd3) begin
            f3 = 3'd2;
          end
          mem[k] = enc_s(align_off(off, f3[1:0]), rs2, f3);
        end
        default: mem[k] = enc_i(tgt[11:0], 5'd0, 3'd0, rd, `RV_OP_JALR);
      endcase
    end
    mem[PROG_LEN] = '0;
  endtask

  // executes ref_mem from the reset pc and queues the expected bus traffic
  task automatic run_model();
    word_t      x [32];
    word_t      pc;
    word_t      npc;
    word_t      w;
    word_t      a;
    word_t      b;
    word_t      v;
    word_t      addr;
    word_t      data;
    word_t      imm_i;
    strb_t      strb;
    logic [2:0] f3;
    reg_addr_t  rd;
    logic       wr;
    logic       stop;
    int         nbytes;
    int         first;
    foreach (x[r]) begin
      x[r] = '0;
    end
    pc   = `RV_RESET_PC;
    stop = 1'b0;
    while (!stop) begin
      exp_fetch.push_back(pc);
      w     = ref_mem[pc[10:2]];
      f3    = w[14:12];
      rd    = w[11:7];
      a     = x[w[19:15]];
      b     = x[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      npc   = pc + 32'd4;
      wr    = 1'b0;
      v     = '0;
      if (w[1:0] != 2'b11) begin
        stop = 1'b1;
      end else begin
        case (w[6:2])
          `RV_OP_LUI: begin
            v  = {w[31:12], 12'b0};
            wr = 1'b1;
          end
          `RV_OP_AUIPC: begin
            v  = pc + {w[31:12], 12'b0};
            wr = 1'b1;
          end
          `RV_OP_JAL: begin
            v   = npc;
            wr  = 1'b1;
            npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
          end
          `RV_OP_JALR: begin
            v   = npc;
            wr  = 1'b1;
            npc = (a + imm_i) & ~32'd1;
          end
          `RV_OP_BRANCH: begin
            if (branch_ref(f3, a, b)) begin
              npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
          end
          `RV_OP_LOAD: begin
            addr = a + imm_i;
            v    = ref_mem[addr[10:2]] >> {addr[1:0], 3'b000};
            wr   = 1'b1;
            case (f3)
              3'd0:    v = {{24{v[7]}}, v[7:0]};
              3'd1:    v = {{16{v[15]}}, v[15:0]};
              3'd4:    v = {24'b0, v[7:0]};
              3'd5:    v = {16'b0, v[15:0]};
              default: v = v;
            endcase
          end
          `RV_OP_STORE: begin
            addr   = a + {{20{w[31]}}, w[31:25], w[11:7]};
            nbytes = 1 << f3[1:0];
            first  = addr[1:0];
            // each lane repeats the stored bytes, only the addressed ones are enabled
            for (int j = 0; j < 4; j++) begin
              data[8*j +: 8] = b[8*(j % nbytes) +: 8];
              strb[j]        = (j >= first) && (j < first + nbytes);
            end
            exp_waddr.push_back({addr[31:2], 2'b00});
            exp_wdata.push_back(data);
            exp_wstrb.push_back(strb);
            for (int j = 0; j < 4; j++) begin
              if (strb[j]) begin
                ref_mem[addr[10:2]][8*j +: 8] = data[8*j +: 8];
              end
            end
          end
          `RV_OP_IMM: begin
            v  = alu_ref(f3, f3 == 3'd5 && w[30], a, imm_i);
            wr = 1'b1;
          end
          `RV_OP_REG: begin
            v  = alu_ref(f3, w[30], a, b);
            wr = 1'b1;
          end
          default: stop = 1'b1;
        endcase
      end
      if (wr && rd != 5'd0) begin
        x[rd] = v;
      end
      pc = npc;
    end
  endtask

  task automatic serve_request();
    logic [8:0] idx;
    idx       = mem_addr[10:2];
    mem_rdata = mem[idx];
    if (mem_instr) begin
      if (exp_fetch.size() == 0) begin
        report_failure("the core fetched beyond the expected instruction sequence");
      end
      check_word("fetch address", mem_addr, exp_fetch.pop_front());
    end else if (mem_wstrb != '0) begin
      if (exp_waddr.size() == 0) begin
        report_failure("the core wrote to memory when no store was expected");
      end
      check_word("store address", mem_addr, exp_waddr.pop_front());
      check_word("store data", mem_wdata, exp_wdata.pop_front());
      check_strb("store strobe", mem_wstrb, exp_wstrb.pop_front());
      for (int j = 0; j < 4; j++) begin
        if (mem_wstrb[j]) begin
          mem[idx][8*j +: 8] = mem_wdata[8*j +: 8];
        end
      end
    end
    mem_ready = 1'b1;
  endtask

  // memory answers after 0 to 3 cycles
  always @(negedge clk) begin
    if (reset || mem_ready) begin
      mem_ready = 1'b0;
      busy      = 1'b0;
    end else if (mem_valid) begin
      if (!busy) begin
        busy  = 1'b1;
        delay = $urandom % 4;
      end
      if (delay == 0) begin
        serve_request();
      end else begin
        delay = delay - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (running) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
        report_failure("timeout: the core did not trap within the cycle limit");
      end
    end
  end

  task automatic run_test(input int n);
    @(negedge clk);
    reset = 1'b1;
    repeat (5) @(negedge clk);
    check_flag("mem_valid in reset", mem_valid, 1'b0);
    check_strb("mem_wstrb in reset", mem_wstrb, '0);
    check_flag("trap in reset", trap, 1'b0);
    cycles  = 0;
    limit   = 40 * n + IDLE_CYCLES;
    running = 1'b1;
    reset   = 1'b0;
    while (!trap) begin
      @(negedge clk);
    end
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      if (mem_valid) begin
        report_failure("the core raised a bus request after the trap");
      end
    end
    running = 1'b0;
    if (exp_fetch.size() != 0) begin
      report_failure("the core trapped before all expected fetches");
    end
    if (exp_waddr.size() != 0) begin
      report_failure("the core trapped before all expected stores");
    end
  endtask

  initial begin
    reset     = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    busy      = 1'b0;
    delay     = 0;
    running   = 1'b0;
    cycles    = 0;
    limit     = 0;
    void'($urandom(3499));

    fill_memory();
    gen_program();
    ref_mem = mem;
    run_model();
    run_test(PROG_LEN + 1);

    // lw x1, 2(x0) must trap without touching the bus
    fill_memory();
    mem[0] = enc_i(12'd2, 5'd0, 3'b010, 5'd1, `RV_OP_LOAD);
    exp_fetch.push_back(`RV_RESET_PC);
    run_test(2);

    // jalr x1, 6(x0) has a target that is not word aligned
    fill_memory();
    mem[0] = enc_i(12'd6, 5'd0, 3'b000, 5'd1, `RV_OP_JALR);
    exp_fetch.push_back(`RV_RESET_PC);
    run_test(2);

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/rv_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_assertions (
  input logic          clk,
  input logic          reset,
  input logic          mem_valid,
  input logic          mem_instr,
  input logic          mem_ready,
  input rv_pkg::word_t mem_addr,
  input rv_pkg::word_t mem_wdata,
  input rv_pkg::strb_t mem_wstrb,
  input logic          trap
);

  // a waiting request keeps every field
  a_request_stable: assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata) &&
      $stable(mem_wstrb) && $stable(mem_instr))
    else $error("bus request changed before ready");

  a_fetch_no_strobe: assert property (@(posedge clk) disable iff (reset)
    mem_valid && mem_instr |-> mem_wstrb == '0)
    else $error("nonzero strobe on an instruction fetch");

  a_trap_sticky: assert property (@(posedge clk) disable iff (reset)
    trap |=> trap)
    else $error("trap dropped without reset");

  a_quiet_after_trap: assert property (@(posedge clk) disable iff (reset)
    trap |-> !mem_valid)
    else $error("bus request while trapped");

endmodule

bind rv_core rv_assertions i_assertions (
  .clk, .reset, .mem_valid, .mem_instr, .mem_ready, .mem_addr, .mem_wdata, .mem_wstrb, .trap
);

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module rv_core (
  input  logic          clk,
  input  logic          reset,
  output logic          mem_valid,
  output logic          mem_instr,
  input  logic          mem_ready,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata,
  output rv_pkg::strb_t mem_wstrb,
  input  rv_pkg::word_t mem_rdata,
  output logic          trap
);
  import rv_pkg::*;

  typedef enum logic [2:0] {
    st_fetch, st_wait, st_decode, st_execute, st_check_pc, st_mem_wait, st_write_back, st_trap
  } state_t;

  state_t    state;
  word_t     pc;
  word_t     instr;
  word_t     regs [`RV_NREGS];
  word_t     rs1_val;
  word_t     rs2_val;
  word_t     wb_data;
  word_t     pc_target;
  word_t     pc_plus4;
  word_t     jump_target;
  logic      skip_wb;
  logic      fetch_valid;
  logic      fetch_ready;
  op_class_t op_class;
  alu_op_t   alu_op;
  branch_t   branch_kind;
  logic      use_imm;
  mem_size_t mem_size;
  logic      mem_unsigned;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     imm;
  word_t     alu_result;
  logic      taken;
  logic      lsu_start;
  logic      lsu_misaligned;
  logic      lsu_done;
  word_t     load_data;
  logic      lsu_valid;
  word_t     lsu_addr;
  word_t     lsu_wdata;
  strb_t     lsu_wstrb;
  logic      lsu_ready;

  rv_decode i_decode (
    .instr, .op_class, .alu_op, .branch_kind, .use_imm, .mem_size, .mem_unsigned,
    .rd, .rs1, .rs2, .imm
  );

  rv_alu i_alu (
    .op(alu_op), .branch_kind, .a(rs1_val), .b(use_imm ? imm : rs2_val),
    .result(alu_result), .taken
  );

  // load/store address is rs1 + imm out of the alu
  assign lsu_start = state == st_execute && (op_class == class_load || op_class == class_store);

  rv_lsu i_lsu (
    .clk, .reset, .start(lsu_start), .addr(alu_result), .store_data(rs2_val),
    .is_store(op_class == class_store), .size(mem_size), .load_unsigned(mem_unsigned),
    .bus_ready(lsu_ready), .bus_rdata(mem_rdata), .misaligned(lsu_misaligned),
    .done(lsu_done), .load_data, .lsu_valid, .lsu_addr, .lsu_wdata, .lsu_wstrb
  );

  rv_bus_arbiter i_arbiter (
    .clk, .reset, .fetch_valid, .fetch_addr(pc), .lsu_valid, .lsu_addr, .lsu_wdata,
    .lsu_wstrb, .mem_ready, .fetch_ready, .lsu_ready, .mem_valid, .mem_instr, .mem_addr,
    .mem_wdata, .mem_wstrb
  );

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (op_class)
      class_jalr:   jump_target = alu_result & ~word_t'(1);
      class_branch: jump_target = taken ? pc + imm : pc_plus4;
      default:      jump_target = pc + imm;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_fetch;
      pc          <= `RV_RESET_PC;
      fetch_valid <= 1'b0;
      trap        <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          fetch_valid <= 1'b1;
          state       <= st_wait;
        end
        st_wait: begin
          if (fetch_ready) begin
            fetch_valid <= 1'b0;
            state       <= st_decode;
          end
        end
        st_decode: state <= st_execute;
        st_execute: begin
          case (op_class)
            class_lui, class_auipc, class_alu: begin
              pc    <= pc_plus4;
              state <= st_write_back;
            end
            class_jal, class_jalr, class_branch: state <= st_check_pc;
            class_load, class_store: state <= lsu_misaligned ? st_trap : st_mem_wait;
            default: state <= st_trap;
          endcase
        end
        // targets must be word aligned
        st_check_pc: begin
          if (pc_target[1:0] != 2'b00) begin
            state <= st_trap;
          end else begin
            pc    <= pc_target;
            state <= skip_wb ? st_fetch : st_write_back;
          end
        end
        st_mem_wait: begin
          if (lsu_done) begin
            pc    <= pc_plus4;
            state <= (op_class == class_store) ? st_fetch : st_write_back;
          end
        end
        st_write_back: state <= st_fetch;
        default: trap <= 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_wait && fetch_ready) begin
      instr <= mem_rdata;
    end
    // x0 always reads back as zero
    if (state == st_decode) begin
      rs1_val <= (rs1 == '0) ? '0 : regs[rs1];
      rs2_val <= (rs2 == '0) ? '0 : regs[rs2];
    end
    if (state == st_execute) begin
      pc_target <= jump_target;
      skip_wb   <= op_class == class_branch;
      case (op_class)
        class_lui:             wb_data <= imm;
        class_auipc:           wb_data <= pc + imm;
        class_jal, class_jalr: wb_data <= pc_plus4;
        default:               wb_data <= alu_result;
      endcase
    end
    if (state == st_mem_wait && lsu_done) begin
      wb_data <= load_data;
    end
    if (state == st_write_back && rd != '0) begin
      regs[rd] <= wb_data;
    end
  end

endmodule

`default_nettype wire

/* source/rv_bus_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_bus_arbiter (
  input  logic          clk,
  input  logic          reset,
  input  logic          fetch_valid,
  input  rv_pkg::word_t fetch_addr,
  input  logic          lsu_valid,
  input  rv_pkg::word_t lsu_addr,
  input  rv_pkg::word_t lsu_wdata,
  input  rv_pkg::strb_t lsu_wstrb,
  input  logic          mem_ready,
  output logic          fetch_ready,
  output logic          lsu_ready,
  output logic          mem_valid,
  output logic          mem_instr,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata,
  output rv_pkg::strb_t mem_wstrb
);

  logic busy;
  logic grant_fetch;
  logic sel_fetch;

  // owner is locked while a transfer is open, otherwise fetch wins
  assign sel_fetch = busy ? grant_fetch : fetch_valid;

  assign mem_valid = sel_fetch ? fetch_valid : lsu_valid;
  assign mem_instr = sel_fetch;
  assign mem_addr  = sel_fetch ? fetch_addr : lsu_addr;
  assign mem_wdata = sel_fetch ? '0 : lsu_wdata;
  assign mem_wstrb = sel_fetch ? '0 : lsu_wstrb;

  assign fetch_ready = sel_fetch && fetch_valid && mem_ready;
  assign lsu_ready   = !sel_fetch && lsu_valid && mem_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy        <= 1'b0;
      grant_fetch <= 1'b0;
    end else if (mem_valid) begin
      busy        <= !mem_ready;
      grant_fetch <= sel_fetch;
    end
  end

endmodule

`default_nettype wire

/* source/rv_lsu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_lsu (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  rv_pkg::word_t     addr,
  input  rv_pkg::word_t     store_data,
  input  logic              is_store,
  input  rv_pkg::mem_size_t size,
  input  logic              load_unsigned,
  input  logic              bus_ready,
  input  rv_pkg::word_t     bus_rdata,
  output logic              misaligned,
  output logic              done,
  output rv_pkg::word_t     load_data,
  output logic              lsu_valid,
  output rv_pkg::word_t     lsu_addr,
  output rv_pkg::word_t     lsu_wdata,
  output rv_pkg::strb_t     lsu_wstrb
);
  import rv_pkg::*;

  logic [1:0] offset;
  mem_size_t  size_q;
  logic       unsigned_q;
  strb_t      lane_strb;
  word_t      lane_data;
  word_t      shifted;

  assign misaligned = start &&
    ((size == size_half && addr[0]) || (size == size_word && addr[1:0] != 2'b00));

  // store data goes out on every lane, the strobe picks the bytes
  always_comb begin
    case (size)
      size_byte: begin
        lane_strb = strb_t'(4'b0001 << addr[1:0]);
        lane_data = {4{store_data[7:0]}};
      end
      size_half: begin
        lane_strb = addr[1] ? 4'b1100 : 4'b0011;
        lane_data = {2{store_data[15:0]}};
      end
      default: begin
        lane_strb = 4'b1111;
        lane_data = store_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lsu_valid <= 1'b0;
    end else if (start && !misaligned) begin
      lsu_valid <= 1'b1;
    end else if (bus_ready) begin
      lsu_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lsu_wstrb <= '0;
    end else if (start) begin
      lsu_addr   <= {addr[$bits(word_t)-1:2], 2'b00};
      lsu_wdata  <= lane_data;
      lsu_wstrb  <= is_store ? lane_strb : '0;
      offset     <= addr[1:0];
      size_q     <= size;
      unsigned_q <= load_unsigned;
    end
  end

  assign done = lsu_valid && bus_ready;

  // bring the addressed lane down to bit 0
  assign shifted = bus_rdata >> {offset, 3'b000};

  always_comb begin
    case (size_q)
      size_byte: load_data = {{24{!unsigned_q && shifted[7]}}, shifted[7:0]};
      size_half: load_data = {{16{!unsigned_q && shifted[15]}}, shifted[15:0]};
      default:   load_data = shifted;
    endcase
  end

endmodule

`default_nettype wire

/* source/rv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::branch_t branch_kind,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result,
  output logic            taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign eq    = a == b;
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = word_t'(lt_s);
      alu_sltu: result = word_t'(lt_u);
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = word_t'($signed(a) >>> shamt);
      alu_or:   result = a | b;
      default:  result = a & b;
    endcase
  end

  // branch compare runs alongside the arithmetic
  always_comb begin
    case (branch_kind)
      br_beq:  taken = eq;
      br_bne:  taken = !eq;
      br_blt:  taken = lt_s;
      br_bge:  taken = !lt_s;
      br_bltu: taken = lt_u;
      default: taken = !lt_u;
    endcase
  end

endmodule

`default_nettype wire

/* source/rv_decode.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module rv_decode (
  input  rv_pkg::word_t     instr,
  output rv_pkg::op_class_t op_class,
  output rv_pkg::alu_op_t   alu_op,
  output rv_pkg::branch_t   branch_kind,
  output logic              use_imm,
  output rv_pkg::mem_size_t mem_size,
  output logic              mem_unsigned,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     imm
);
  import rv_pkg::*;

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic       f7_base;
  logic       f7_alt;
  alu_op_t    f3_op;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode  = instr[6:2];
  assign funct3  = instr[14:12];
  assign f7_base = instr[31:25] == `RV_F7_BASE;
  assign f7_alt  = instr[31:25] == `RV_F7_ALT;

  assign rd  = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  assign branch_kind  = branch_t'(funct3);
  assign mem_size     = mem_size_t'(funct3[1:0]);
  assign mem_unsigned = funct3[2];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 picks the operation, funct7 only splits the right shifts here
  always_comb begin
    case (funct3)
      3'b000:  f3_op = alu_add;
      3'b001:  f3_op = alu_sll;
      3'b010:  f3_op = alu_slt;
      3'b011:  f3_op = alu_sltu;
      3'b100:  f3_op = alu_xor;
      3'b101:  f3_op = f7_alt ? alu_sra : alu_srl;
      3'b110:  f3_op = alu_or;
      default: f3_op = alu_and;
    endcase
  end

  always_comb begin
    op_class = class_invalid;
    alu_op   = alu_add;
    use_imm  = 1'b0;
    // anything with low bits other than 11 is left invalid
    if (instr[1:0] == 2'b11) begin
      case (opcode)
        `RV_OP_LUI:   op_class = class_lui;
        `RV_OP_AUIPC: op_class = class_auipc;
        `RV_OP_JAL:   op_class = class_jal;
        `RV_OP_JALR: begin
          use_imm = 1'b1;
          if (funct3 == 3'b000) begin
            op_class = class_jalr;
          end
        end
        `RV_OP_BRANCH: begin
          if (funct3[2:1] != 2'b01) begin
            op_class = class_branch;
          end
        end
        `RV_OP_LOAD: begin
          use_imm = 1'b1;
          if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
            op_class = class_load;
          end
        end
        `RV_OP_STORE: begin
          use_imm = 1'b1;
          if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
            op_class = class_store;
          end
        end
        `RV_OP_IMM: begin
          use_imm = 1'b1;
          alu_op  = f3_op;
          // shift immediates carry funct7 in the upper bits
          if (funct3[1:0] != 2'b01 || f7_base || (f7_alt && funct3 == 3'b101)) begin
            op_class = class_alu;
          end
        end
        `RV_OP_REG: begin
          alu_op = (funct3 == 3'b000 && f7_alt) ? alu_sub : f3_op;
          if (f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
            op_class = class_alu;
          end
        end
        default: op_class = class_invalid;
      endcase
    end
  end

  always_comb begin
    case (op_class)
      class_lui, class_auipc: imm = imm_u;
      class_jal:              imm = imm_j;
      class_branch:           imm = imm_b;
      class_store:            imm = imm_s;
      default:                imm = imm_i;
    endcase
  end

endmodule

`default_nettype wire

/* source/rv_pkg.sv */
`default_nettype none
`include "rv_defines.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_XLEN/8-1:0] strb_t;
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  // same encoding as the branch funct3
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_t;

  typedef enum logic [3:0] {
    class_lui,
    class_auipc,
    class_jal,
    class_jalr,
    class_branch,
    class_load,
    class_store,
    class_alu,
    class_invalid
  } op_class_t;

  // low two bits of the load/store funct3
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_t;

endpackage

`default_nettype wire

/* source/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// machine width and register file size
`define RV_XLEN     32
`define RV_NREGS    32
`define RV_RESET_PC 32'h0000_0000

// major opcodes in instr[6:2]
`define RV_OP_LUI    5'b01101
`define RV_OP_AUIPC  5'b00101
`define RV_OP_JAL    5'b11011
`define RV_OP_JALR   5'b11001
`define RV_OP_BRANCH 5'b11000
`define RV_OP_LOAD   5'b00000
`define RV_OP_STORE  5'b01000
`define RV_OP_IMM    5'b00100
`define RV_OP_REG    5'b01100

// funct7 of the base and alternate alu operations
`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000

`endif
